// File: Makefile
# Verilator build and run for the LM80C glue core

VERILATOR ?= verilator
TOP       ?= lm80c_core_tb
FLIST     ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The run passes only when the pass line shows up in the output
run: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: sim.f
+incdir+source
source/lm80c_bus_pkg.sv
source/lm80c_mem_pkg.sv
source/io_decoder.sv
source/system_memory.sv
source/ram_eraser.sv
source/boot_monitor.sv
source/audio_dac.sv
source/lm80c_core.sv
test/lm80c_core_sva.sv
test/lm80c_core_tb.sv

// File: source/audio_dac.sv
// Mono PSG mix into a first order sigma-delta DAC. The output bit needs an external RC filter
`timescale 1ns/10ps
`default_nettype none

`include "lm80c_defines.svh"

module audio_dac (
	input  wire                          CLOCK,
	input  wire                          rst_n_i,
	input  wire lm80c_mem_pkg::psg_mix_t psg_i,
	output logic                         audio_o    // Pulse density output
);

	logic [9:0]                 mix_sum;  // Three channels, no overflow
	lm80c_mem_pkg::dac_sample_t sample;
	logic [`LM80C_DAC_W:0]      acc_q;    // Carry in the top bit

	assign mix_sum = 10'(psg_i.a) + 10'(psg_i.b) + 10'(psg_i.c);
	assign sample  = {mix_sum, {(`LM80C_DAC_W - 10){1'b0}}};  // Left aligned

	// Drop the old carry and add the sample every clock
	always_ff @(posedge CLOCK or negedge rst_n_i) begin
		if (!rst_n_i)
			acc_q <= '0;
		else
			acc_q <= {1'b0, acc_q[`LM80C_DAC_W-1:0]} + {1'b0, sample};
	end

	assign audio_o = acc_q[`LM80C_DAC_W];

endmodule

`default_nettype wire

// File: source/boot_monitor.sv
// Holds the Z80 until boot ends and checks four signature bytes after every reset release with no download or erase
`timescale 1ns/10ps
`default_nettype none

`include "lm80c_defines.svh"

module boot_monitor (
	input  wire                          CLOCK,
	input  wire                          rst_n_i,
	input  wire                          rom_done_i,
	input  wire                          reset_key_i,
	input  wire                          downloading_i,
	input  wire                          erasing_i,
	input  wire lm80c_bus_pkg::data_t    ram_rdata_i,
	input  wire                          led_wr_i,
	input  wire                          led_bit_i,
	output lm80c_mem_pkg::ram_addr_t     chk_addr_o,
	output logic                         checking_o,
	output logic                         cpu_reset_n_o,
	output logic                         cpu_wait_o,
	output logic                         led_o
);

	lm80c_mem_pkg::mon_state_t state_q;
	logic [2:0]                chk_cnt_q;    // Address read this clock
	logic [2:0]                match_cnt_q;  // Bytes matched so far
	logic [2:0]                match_next;
	lm80c_bus_pkg::data_t      sig_byte;
	logic                      byte_hit;
	logic                      run_ok;       // Reset released, port free
	logic                      last_chk;

	assign cpu_reset_n_o = rom_done_i && !reset_key_i;
	assign run_ok        = cpu_reset_n_o && !downloading_i && !erasing_i;
	assign checking_o    = (state_q == lm80c_mem_pkg::CHECK);
	assign cpu_wait_o    = !rom_done_i || downloading_i || erasing_i || checking_o;
	assign chk_addr_o    = lm80c_mem_pkg::ram_addr_t'(chk_cnt_q);

	// Byte expected for the data read one clock earlier
	always_comb begin
		case (chk_cnt_q)
			3'd1:    sig_byte = `LM80C_SIG_0;
			3'd2:    sig_byte = `LM80C_SIG_1;
			3'd3:    sig_byte = `LM80C_SIG_2;
			default: sig_byte = `LM80C_SIG_3;
		endcase
	end

	assign byte_hit   = (chk_cnt_q != 3'd0) && (ram_rdata_i == sig_byte);
	assign match_next = match_cnt_q + {2'b00, byte_hit};
	assign last_chk   = checking_o && run_ok && (chk_cnt_q == 3'(`LM80C_SIG_LEN));

	always_ff @(posedge CLOCK or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q     <= lm80c_mem_pkg::HOLD;
			chk_cnt_q   <= '0;
			match_cnt_q <= '0;
			led_o       <= 1'b0;
		end else begin
			case (state_q)
				lm80c_mem_pkg::HOLD: begin
					chk_cnt_q   <= '0;
					match_cnt_q <= '0;
					if (run_ok)
						state_q <= lm80c_mem_pkg::CHECK;
				end
				lm80c_mem_pkg::CHECK: begin
					if (!run_ok) begin
						state_q <= lm80c_mem_pkg::HOLD;  // Restart after the hold
					end else begin
						chk_cnt_q   <= chk_cnt_q + 3'd1;
						match_cnt_q <= match_next;
						if (last_chk)
							state_q <= lm80c_mem_pkg::DONE;
					end
				end
				lm80c_mem_pkg::DONE: begin
					if (!run_ok)
						state_q <= lm80c_mem_pkg::HOLD;  // Key press or new download
				end
				default: state_q <= lm80c_mem_pkg::HOLD;
			endcase
			// Check result wins over a port write in the same clock
			if (last_chk)
				led_o <= (match_next == 3'(`LM80C_SIG_LEN));
			else if (led_wr_i && led_bit_i)
				led_o <= !led_o;
		end
	end

endmodule

`default_nettype wire

// File: source/io_decoder.sv
// Decodes only A7 to A4 of I/O cycles and gives CPU read data two clocks after the bus is presented
`timescale 1ns/10ps
`default_nettype none

`include "lm80c_defines.svh"

module io_decoder (
	input  wire                             CLOCK,
	input  wire                             rst_n_i,
	input  wire lm80c_bus_pkg::cpu_bus_t    bus_i,
	input  wire lm80c_bus_pkg::data_t       ram_rdata_i,  // Already one clock late
	input  wire lm80c_bus_pkg::dev_rdata_t  dev_rdata_i,
	output lm80c_bus_pkg::io_sel_t          io_sel_o,
	output logic                            led_wr_o,     // One clock per LED write
	output logic                            led_bit_o,
	output lm80c_bus_pkg::data_t            cpu_rdata_o
);

	logic       io_cycle;   // IORQ low outside memory cycles
	logic [3:0] group;
	logic       led_hit;    // LED write on the bus now
	logic       led_hit_q;

	assign io_cycle = !bus_i.iorq_n && bus_i.mreq_n;
	assign group    = bus_i.addr[7:4];
	assign led_hit  = io_cycle && !bus_i.wr_n && (group == `LM80C_PORT_LED);

	// First stage: chip selects
	always_ff @(posedge CLOCK or negedge rst_n_i) begin
		if (!rst_n_i) begin
			io_sel_o  <= '0;
			led_hit_q <= 1'b0;
			led_wr_o  <= 1'b0;
			led_bit_o <= 1'b0;
		end else begin
			io_sel_o.pio <= io_cycle && (group == `LM80C_PORT_PIO);
			io_sel_o.ctc <= io_cycle && (group == `LM80C_PORT_CTC);
			io_sel_o.sio <= io_cycle && (group == `LM80C_PORT_SIO);
			io_sel_o.vdp <= io_cycle && (group == `LM80C_PORT_VDP);
			io_sel_o.psg <= io_cycle && (group == `LM80C_PORT_PSG);
			io_sel_o.led <= io_cycle && (group == `LM80C_PORT_LED);
			led_hit_q    <= led_hit;
			led_wr_o     <= led_hit && !led_hit_q;  // Leading edge only
			led_bit_o    <= bus_i.wdata[0];
		end
	end

	// Second stage: read mux on the registered selects
	always_ff @(posedge CLOCK) begin
		if (io_sel_o.ctc)
			cpu_rdata_o <= dev_rdata_i.ctc;
		else if (io_sel_o.vdp)
			cpu_rdata_o <= dev_rdata_i.vdp;
		else if (io_sel_o.psg)
			cpu_rdata_o <= dev_rdata_i.psg;
		else if (io_sel_o.pio || io_sel_o.sio)
			cpu_rdata_o <= '0;  // No read path modelled
		else
			cpu_rdata_o <= ram_rdata_i;
	end

endmodule

`default_nettype wire

// File: source/lm80c_bus_pkg.sv
// CPU side types. Bus strobes stay active low as on the Z80 and only the low address byte selects I/O
`default_nettype none

`include "lm80c_defines.svh"

package lm80c_bus_pkg;

	typedef logic [`LM80C_DATA_W-1:0] data_t;  // One byte
	typedef logic [`LM80C_ADDR_W-1:0] addr_t;  // CPU address

	// Z80 bus as seen by the glue logic
	typedef struct packed {
		addr_t addr;     // A15..A0
		data_t wdata;    // CPU data out
		logic  rd_n;
		logic  wr_n;
		logic  mreq_n;   // Memory cycle
		logic  iorq_n;   // I/O cycle
	} cpu_bus_t;

	// Registered chip selects, at most one high
	typedef struct packed {
		logic pio;
		logic ctc;
		logic sio;
		logic vdp;
		logic psg;
		logic led;       // Debug LED port
	} io_sel_t;

	// Read bytes of the peripherals that answer reads
	typedef struct packed {
		data_t ctc;
		data_t vdp;
		data_t psg;
	} dev_rdata_t;

endpackage

`default_nettype wire

// File: source/lm80c_core.sv
// LM80C glue core on one clock. CPU, video, PSG and the download controller live outside and meet it through ports
`timescale 1ns/10ps
`default_nettype none

module lm80c_core (
	input  wire                             CLOCK,
	input  wire                             rst_n_i,
	input  wire lm80c_bus_pkg::cpu_bus_t    cpu_bus_i,    // Z80 bus
	input  wire lm80c_bus_pkg::dev_rdata_t  dev_rdata_i,  // CTC, VDP, PSG read bytes
	input  wire lm80c_mem_pkg::ram_wr_t     dl_i,         // Download writes
	input  wire                             downloading_i,
	input  wire                             rom_done_i,
	input  wire                             erase_i,      // Erase trigger
	input  wire                             reset_key_i,
	input  wire lm80c_mem_pkg::psg_mix_t    psg_i,
	output wire lm80c_bus_pkg::data_t       cpu_rdata_o,  // Z80 data in
	output wire lm80c_bus_pkg::io_sel_t     io_sel_o,
	output wire                             cpu_reset_n_o,
	output wire                             cpu_wait_o,
	output wire                             led_o,
	output wire                             audio_o
);

	wire lm80c_bus_pkg::data_t     ram_rdata;  // Shared RAM read data
	wire lm80c_mem_pkg::ram_wr_t   er;         // Eraser write request
	wire                           erasing;
	wire lm80c_mem_pkg::ram_addr_t chk_addr;   // Signature read address
	wire                           checking;
	wire                           led_wr;     // LED port write pulse
	wire                           led_bit;

	// Port decode and CPU read mux
	io_decoder u_io_decoder (
		.CLOCK       (CLOCK),
		.rst_n_i     (rst_n_i),
		.bus_i       (cpu_bus_i),
		.ram_rdata_i (ram_rdata),
		.dev_rdata_i (dev_rdata_i),
		.io_sel_o    (io_sel_o),
		.led_wr_o    (led_wr),
		.led_bit_o   (led_bit),
		.cpu_rdata_o (cpu_rdata_o)
	);

	system_memory u_system_memory (
		.CLOCK         (CLOCK),
		.rst_n_i       (rst_n_i),
		.bus_i         (cpu_bus_i),
		.dl_i          (dl_i),
		.downloading_i (downloading_i),
		.er_i          (er),
		.erasing_i     (erasing),
		.chk_addr_i    (chk_addr),
		.checking_i    (checking),
		.rdata_o       (ram_rdata)
	);

	ram_eraser u_ram_eraser (
		.CLOCK     (CLOCK),
		.rst_n_i   (rst_n_i),
		.erase_i   (erase_i),
		.er_o      (er),
		.erasing_o (erasing)
	);

	// CPU reset, wait and LED
	boot_monitor u_boot_monitor (
		.CLOCK         (CLOCK),
		.rst_n_i       (rst_n_i),
		.rom_done_i    (rom_done_i),
		.reset_key_i   (reset_key_i),
		.downloading_i (downloading_i),
		.erasing_i     (erasing),
		.ram_rdata_i   (ram_rdata),
		.led_wr_i      (led_wr),
		.led_bit_i     (led_bit),
		.chk_addr_o    (chk_addr),
		.checking_o    (checking),
		.cpu_reset_n_o (cpu_reset_n_o),
		.cpu_wait_o    (cpu_wait_o),
		.led_o         (led_o)
	);

	audio_dac u_audio_dac (
		.CLOCK   (CLOCK),
		.rst_n_i (rst_n_i),
		.psg_i   (psg_i),
		.audio_o (audio_o)
	);

endmodule

`default_nettype wire

// File: source/lm80c_defines.svh
// Widths, port groups and boot constants for the core. The RAM is fixed at 32 KiB and the signature at four bytes
`ifndef LM80C_DEFINES_SVH
`define LM80C_DEFINES_SVH

// Bus widths
`define LM80C_DATA_W      8    // Z80 data byte
`define LM80C_ADDR_W      16   // Z80 address bus
`define LM80C_RAM_ADDR_W  15   // 32 KiB system RAM

// I/O port groups, taken from A7..A4 of the I/O address
`define LM80C_PORT_PIO    4'h0
`define LM80C_PORT_CTC    4'h1
`define LM80C_PORT_SIO    4'h2
`define LM80C_PORT_VDP    4'h3
`define LM80C_PORT_PSG    4'h4
`define LM80C_PORT_LED    4'h7   // Debug LED at 0x70

// Program signature expected at address 0
`define LM80C_SIG_0       8'hF3  // di
`define LM80C_SIG_1       8'hC3  // jp
`define LM80C_SIG_2       8'h5A
`define LM80C_SIG_3       8'h02
`define LM80C_SIG_LEN     4

// Eraser fill value
`define LM80C_ERASE_FILL  8'h00

// Sigma-delta input width
`define LM80C_DAC_W       16

`endif

// File: source/lm80c_mem_pkg.sv
// RAM port, boot monitor and audio types. One write request per clock and no handshake on the port
`default_nettype none

`include "lm80c_defines.svh"

package lm80c_mem_pkg;

	typedef logic [`LM80C_RAM_ADDR_W-1:0] ram_addr_t;  // 32 KiB address

	// One write request into the RAM port
	typedef struct packed {
		logic                     wr;    // Write strobe
		ram_addr_t                addr;
		logic [`LM80C_DATA_W-1:0] data;
	} ram_wr_t;

	typedef logic [7:0] psg_chan_t;  // Unsigned PSG level

	// The three PSG channels
	typedef struct packed {
		psg_chan_t a;
		psg_chan_t b;
		psg_chan_t c;
	} psg_mix_t;

	typedef logic [`LM80C_DAC_W-1:0] dac_sample_t;  // Full scale DAC input

	// Boot monitor FSM
	typedef enum logic [1:0] {
		HOLD,   // CPU in reset or port busy
		CHECK,  // Signature read and compare
		DONE    // CPU running
	} mon_state_t;

endpackage

`default_nettype wire

// File: source/ram_eraser.sv
// Fills every RAM byte once per rising trigger edge and ignores triggers that arrive during a sweep
`timescale 1ns/10ps
`default_nettype none

`include "lm80c_defines.svh"

module ram_eraser (
	input  wire                       CLOCK,
	input  wire                       rst_n_i,
	input  wire                       erase_i,    // Trigger level
	output lm80c_mem_pkg::ram_wr_t    er_o,
	output logic                      erasing_o   // High for 2^15 clocks
);

	logic                      erase_q;  // Trigger delayed one clock
	logic                      start;
	lm80c_mem_pkg::ram_addr_t  addr_q;

	assign start = erase_i && !erase_q && !erasing_o;

	always_ff @(posedge CLOCK or negedge rst_n_i) begin
		if (!rst_n_i) begin
			erase_q   <= 1'b0;
			erasing_o <= 1'b0;
			addr_q    <= '0;
		end else begin
			erase_q <= erase_i;
			if (start) begin
				erasing_o <= 1'b1;
				addr_q    <= '0;
			end else if (erasing_o) begin
				addr_q <= addr_q + 1'b1;  // Wraps back to 0
				if (&addr_q)
					erasing_o <= 1'b0;      // Last address written
			end
		end
	end

	// One write per clock while sweeping
	assign er_o = '{wr: erasing_o, addr: addr_q, data: `LM80C_ERASE_FILL};

endmodule

`default_nettype wire

// File: source/system_memory.sv
// Single port 32 KiB RAM where CPU writes land only with A15 set and the low 15 address bits index the array
`timescale 1ns/10ps
`default_nettype none

`include "lm80c_defines.svh"

module system_memory (
	input  wire                             CLOCK,
	input  wire                             rst_n_i,
	input  wire lm80c_bus_pkg::cpu_bus_t    bus_i,
	input  wire lm80c_mem_pkg::ram_wr_t     dl_i,
	input  wire                             downloading_i,
	input  wire lm80c_mem_pkg::ram_wr_t     er_i,
	input  wire                             erasing_i,
	input  wire lm80c_mem_pkg::ram_addr_t   chk_addr_i,
	input  wire                             checking_i,
	output lm80c_bus_pkg::data_t            rdata_o      // One clock after the address
);

	localparam int unsigned DEPTH = 2 ** `LM80C_RAM_ADDR_W;

	lm80c_bus_pkg::data_t   mem [DEPTH];
	lm80c_mem_pkg::ram_wr_t ram_port;  // Winner of arbitration
	logic                   port_rd;
	logic                   cpu_wr;
	logic                   cpu_rd;

	// Upper half only, lower half keeps the program
	assign cpu_wr = !bus_i.mreq_n && !bus_i.wr_n && bus_i.addr[`LM80C_ADDR_W-1];
	assign cpu_rd = !bus_i.mreq_n && !bus_i.rd_n;

	// Fixed priority: download, erase, check, CPU
	always_comb begin
		port_rd = 1'b1;
		if (downloading_i) begin
			ram_port = dl_i;
		end else if (erasing_i) begin
			ram_port = er_i;
		end else if (checking_i) begin
			ram_port = '{wr: 1'b0, addr: chk_addr_i, data: '0};  // Read only
		end else begin
			ram_port.wr   = cpu_wr;
			ram_port.addr = bus_i.addr[`LM80C_RAM_ADDR_W-1:0];
			ram_port.data = bus_i.wdata;
			port_rd       = cpu_rd;  // Hold last byte between CPU reads
		end
	end

	always_ff @(posedge CLOCK) begin
		if (ram_port.wr)
			mem[ram_port.addr] <= ram_port.data;
	end

	// Read first on a collision
	always_ff @(posedge CLOCK or negedge rst_n_i) begin
		if (!rst_n_i)
			rdata_o <= '0;
		else if (port_rd)
			rdata_o <= mem[ram_port.addr];
	end

endmodule

`default_nettype wire

// File: test/lm80c_core_sva.sv
// Checks of the core outputs against reset, boot and erase levels. Bound into every lm80c_core instance
`timescale 1ns/10ps
`default_nettype none

module lm80c_core_sva (
	input wire                          CLOCK,
	input wire                          rst_n_i,
	input wire lm80c_bus_pkg::io_sel_t  io_sel_o,
	input wire                          cpu_wait_o,
	input wire                          cpu_reset_n_o,
	input wire                          rom_done_i,
	input wire                          erasing_i      // Internal eraser level
);

	// No two peripherals selected at once
	sel_onehot: assert property (@(posedge CLOCK) disable iff (!rst_n_i)
		$onehot0(io_sel_o))
		else $error("more than one chip select high");

	// CPU parked during the sweep
	wait_on_erase: assert property (@(posedge CLOCK) disable iff (!rst_n_i)
		erasing_i |-> cpu_wait_o)
		else $error("CPU not held while the RAM is erased");

	reset_on_boot: assert property (@(posedge CLOCK) disable iff (!rst_n_i)
		!rom_done_i |-> !cpu_reset_n_o)
		else $error("CPU out of reset before boot finished");

endmodule

bind lm80c_core lm80c_core_sva sva_i (
	.CLOCK         (CLOCK),
	.rst_n_i       (rst_n_i),
	.io_sel_o      (io_sel_o),
	.cpu_wait_o    (cpu_wait_o),
	.cpu_reset_n_o (cpu_reset_n_o),
	.rom_done_i    (rom_done_i),
	.erasing_i     (erasing)
);

`default_nettype wire

// File: test/lm80c_core_tb.sv
// Testbench for the glue core. One erase sweep and a 65536 clock audio window dominate the run time
`timescale 1ns/10ps
`default_nettype none

`include "lm80c_defines.svh"

module lm80c_core_tb;

	localparam int MAX_CYCLES = 2**15 + 2**16 + 6000;  // Erase + audio window + margin

	logic CLOCK = 1'b0;
	logic rst_n_i;
	lm80c_bus_pkg::cpu_bus_t   cpu_bus_i;
	lm80c_bus_pkg::dev_rdata_t dev_rdata_i;
	lm80c_mem_pkg::ram_wr_t    dl_i;
	logic downloading_i, rom_done_i, erase_i, reset_key_i;
	lm80c_mem_pkg::psg_mix_t   psg_i;
	lm80c_bus_pkg::data_t      cpu_rdata_o;
	lm80c_bus_pkg::io_sel_t    io_sel_o;
	logic cpu_reset_n_o, cpu_wait_o, led_o, audio_o;

	logic [7:0]  ref_mem [2**`LM80C_RAM_ADDR_W];  // Reference RAM
	logic [31:0] lfsr_q = 32'hd2bab140;
	int          cyc_cnt = 0;
	int          err_cnt = 0;
	int          chk_cnt = 0;
	int          test_cnt = 0;
	int          test_err0 = 0;

	lm80c_core dut_i (.*);

	always #4 CLOCK = !CLOCK;  // 8 ns period

	// Watchdog
	always @(posedge CLOCK) begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt >= MAX_CYCLES) begin
			$display("Timeout: the run went past %0d clock cycles", MAX_CYCLES);
			$display("Result: FAILED");
			$finish;
		end
	end

	// Taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v      = {v[30:0], lfsr_q[0]};  // One step per bit
		end
	endtask

	function automatic lm80c_bus_pkg::cpu_bus_t make_bus(input logic [15:0] a, input logic [7:0] d,
			input logic rd_n, input logic wr_n, input logic mreq_n, input logic iorq_n);
		return '{addr: a, wdata: d, rd_n: rd_n, wr_n: wr_n, mreq_n: mreq_n, iorq_n: iorq_n};
	endfunction

	// Reference write rules: download first, else CPU writes with A15 set
	function automatic void ref_apply(input logic dl_busy, input lm80c_mem_pkg::ram_wr_t dl,
			input lm80c_bus_pkg::cpu_bus_t bus);
		if (dl_busy) begin
			if (dl.wr)
				ref_mem[dl.addr] = dl.data;
		end else if (!bus.mreq_n && !bus.wr_n && bus.addr[15]) begin
			ref_mem[bus.addr[14:0]] = bus.wdata;
		end
	endfunction

	function automatic lm80c_bus_pkg::io_sel_t ref_sel(input logic [3:0] g);
		lm80c_bus_pkg::io_sel_t s;
		s = '0;
		case (g)
			`LM80C_PORT_PIO: s.pio = 1'b1;
			`LM80C_PORT_CTC: s.ctc = 1'b1;
			`LM80C_PORT_SIO: s.sio = 1'b1;
			`LM80C_PORT_VDP: s.vdp = 1'b1;
			`LM80C_PORT_PSG: s.psg = 1'b1;
			`LM80C_PORT_LED: s.led = 1'b1;
			default: s = '0;  // Unused groups
		endcase
		return s;
	endfunction

	function automatic logic [7:0] ref_dev(input logic [3:0] g, input lm80c_bus_pkg::dev_rdata_t d);
		case (g)
			`LM80C_PORT_CTC: return d.ctc;
			`LM80C_PORT_VDP: return d.vdp;
			`LM80C_PORT_PSG: return d.psg;
			default:         return 8'h00;  // PIO and SIO
		endcase
	endfunction

	// Mixed sample equals the ones count over 2^16 clocks
	function automatic int ref_audio(input lm80c_mem_pkg::psg_mix_t p);
		return (int'(p.a) + int'(p.b) + int'(p.c)) * 64;
	endfunction

	task automatic check_val(input string name, input int got, input int exp, input int tol);
		chk_cnt++;
		if (got > exp + tol || got < exp - tol) begin
			err_cnt++;
			$display("FAIL t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		$display("test %s finished with %0d errors", name, err_cnt - test_err0);
		test_err0 = err_cnt;
	endtask

	// Hold goes up, then two quiet clocks mean the check is over
	task automatic wait_ready();
		int lows;
		lows = 0;
		do @(negedge CLOCK); while (!cpu_wait_o);
		while (lows < 2) begin
			@(negedge CLOCK);
			lows = cpu_wait_o ? 0 : lows + 1;
		end
	endtask

	task automatic dl_write(input logic [14:0] a, input logic [7:0] d);
		lm80c_mem_pkg::ram_wr_t w;
		w = '{wr: 1'b1, addr: a, data: d};
		@(posedge CLOCK);
		downloading_i <= 1'b1;
		dl_i          <= w;
		ref_apply(1'b1, w, cpu_bus_i);
	endtask

	task automatic dl_end();
		@(posedge CLOCK);
		downloading_i <= 1'b0;
		dl_i          <= '0;
		wait_ready();
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		lm80c_bus_pkg::cpu_bus_t b;
		b = make_bus(a, d, 1'b1, 1'b0, 1'b0, 1'b1);
		@(posedge CLOCK);
		cpu_bus_i <= b;
		ref_apply(1'b0, dl_i, b);
		@(posedge CLOCK);
		cpu_bus_i <= make_bus(16'h0, 8'h0, 1'b1, 1'b1, 1'b1, 1'b1);
	endtask

	task automatic read_check(input logic [15:0] a);
		@(posedge CLOCK);
		cpu_bus_i <= make_bus(a, 8'h0, 1'b0, 1'b1, 1'b0, 1'b1);
		repeat (2) @(posedge CLOCK);
		@(negedge CLOCK);
		check_val("cpu_rdata_o", 32'(cpu_rdata_o), 32'(ref_mem[a[14:0]]), 0);
		@(posedge CLOCK);
		cpu_bus_i <= make_bus(16'h0, 8'h0, 1'b1, 1'b1, 1'b1, 1'b1);
	endtask

	task automatic io_write(input logic [7:0] a, input logic [7:0] d);
		@(posedge CLOCK);
		cpu_bus_i <= make_bus({8'h00, a}, d, 1'b1, 1'b0, 1'b1, 1'b0);
		@(posedge CLOCK);
		cpu_bus_i <= make_bus(16'h0, 8'h0, 1'b1, 1'b1, 1'b1, 1'b1);
		repeat (3) @(posedge CLOCK);
		@(negedge CLOCK);
	endtask

	initial begin
		logic [31:0] v;
		logic [14:0] dl_addrs [$];
		logic        led_prev;
		int          ones;
		rst_n_i = 1'b0;
		cpu_bus_i = make_bus(16'h0, 8'h0, 1'b1, 1'b1, 1'b1, 1'b1);
		dev_rdata_i = '0;
		dl_i = '0;
		downloading_i = 1'b0;
		rom_done_i = 1'b0;
		erase_i = 1'b0;
		reset_key_i = 1'b0;
		psg_i = '0;
		repeat (5) @(posedge CLOCK);
		rst_n_i <= 1'b1;
		@(negedge CLOCK);
		check_val("cpu_reset_n_o", 32'(cpu_reset_n_o), 0, 0);  // Boot not done yet
		check_val("cpu_wait_o", 32'(cpu_wait_o), 1, 0);
		check_val("led_o", 32'(led_o), 0, 0);
		check_val("io_sel_o", 32'(io_sel_o), 0, 0);

		// Erase with boot released at the same clock
		@(posedge CLOCK);
		erase_i    <= 1'b1;
		rom_done_i <= 1'b1;
		@(posedge CLOCK);
		erase_i <= 1'b0;
		wait_ready();
		foreach (ref_mem[i])
			ref_mem[i] = `LM80C_ERASE_FILL;
		for (int i = 0; i < 16; i++) begin
			rand_bits(16, v);
			read_check(v[15:0]);
		end
		end_test("erase");

		// Download, then CPU writes against the protected half
		for (int i = 0; i < 64; i++) begin
			rand_bits(15, v);
			dl_addrs.push_back(v[14:0]);
			rand_bits(8, v);
			dl_write(dl_addrs[i], v[7:0]);
		end
		dl_end();
		for (int i = 0; i < 32; i++) begin
			rand_bits(9, v);
			cpu_write({v[8], dl_addrs[i]}, v[7:0]);
		end
		foreach (dl_addrs[i])
			read_check({1'b0, dl_addrs[i]});
		end_test("download");

		// Boot signature good, then corrupted
		@(posedge CLOCK);
		rom_done_i <= 1'b0;
		dl_write(15'd0, `LM80C_SIG_0);
		dl_write(15'd1, `LM80C_SIG_1);
		dl_write(15'd2, `LM80C_SIG_2);
		dl_write(15'd3, `LM80C_SIG_3);
		@(posedge CLOCK);
		downloading_i <= 1'b0;
		dl_i          <= '0;
		rom_done_i    <= 1'b1;
		wait_ready();
		check_val("led_o", 32'(led_o), 1, 0);
		dl_write(15'd2, 8'h00);
		dl_end();
		io_write(8'h70, 8'h01);  // LED on, only the repeated check clears it
		check_val("led_o", 32'(led_o), 1, 0);
		@(posedge CLOCK);
		reset_key_i <= 1'b1;
		repeat (3) @(posedge CLOCK);
		@(negedge CLOCK);
		check_val("cpu_reset_n_o", 32'(cpu_reset_n_o), 0, 0);
		@(posedge CLOCK);
		reset_key_i <= 1'b0;
		wait_ready();
		check_val("led_o", 32'(led_o), 0, 0);
		end_test("boot");

		// Port groups, read data and LED writes
		for (int g = 0; g < 8; g++) begin
			rand_bits(24, v);
			@(posedge CLOCK);
			dev_rdata_i <= v[23:0];
			cpu_bus_i   <= make_bus({8'h00, 4'(g), 4'h5}, 8'h0, 1'b0, 1'b1, 1'b1, 1'b0);
			@(posedge CLOCK);
			@(negedge CLOCK);
			check_val("io_sel_o", 32'(io_sel_o), 32'(ref_sel(4'(g))), 0);
			@(posedge CLOCK);
			@(negedge CLOCK);
			if (g <= 4)
				check_val("cpu_rdata_o", 32'(cpu_rdata_o), 32'(ref_dev(4'(g), dev_rdata_i)), 0);
			@(posedge CLOCK);
			cpu_bus_i <= make_bus(16'h0, 8'h0, 1'b1, 1'b1, 1'b1, 1'b1);
		end
		led_prev = led_o;
		io_write(8'h70, 8'h01);
		check_val("led_o", 32'(led_o), 32'(!led_prev), 0);
		led_prev = led_o;
		io_write(8'h71, 8'hFE);  // Bit 0 clear
		check_val("led_o", 32'(led_o), 32'(led_prev), 0);
		end_test("io");

		// Sigma-delta density
		rand_bits(24, v);
		@(posedge CLOCK);
		psg_i <= v[23:0];
		repeat (2) @(posedge CLOCK);
		ones = 0;
		for (int i = 0; i < 65536; i++) begin
			@(negedge CLOCK);
			ones += int'(audio_o);
		end
		check_val("audio_o ones", ones, ref_audio(psg_i), 1);
		end_test("audio");

		$display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire
